// ==== dv/au_props.sv ====
//////////////////////////////////////////////////
// apb protocol properties, bound into au_top
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module au_props (
    input wire                    ctl,
    input wire                    reset_i,
    input wire logic              psel_i,
    input wire logic              penable_i,
    input wire logic              pwrite_i,
    input wire logic [3:0]        paddr_i,
    input wire logic              pready_i,
    input wire logic              pslverr_i,
    input wire ej32_pkg::au_cmd_t cmd_i,
    input wire ej32_pkg::au_rsp_t rsp_i
);
    import ej32_pkg::*;

    int fail_cnt = 0;                   // failed properties so far

    // no response without a transfer in progress, reset included
    a_no_stray_ready: assert property (@(posedge ctl)
        (reset_i || !psel_i) |=> !pready_i)
        else begin $error("pready high without an access in progress"); fail_cnt++; end

    a_err_with_ready: assert property (@(posedge ctl) disable iff (reset_i)
        pslverr_i |-> pready_i)
        else begin $error("pslverr high while pready is low"); fail_cnt++; end

    // instruction writes always take at least one wait state
    a_instr_wait: assert property (@(posedge ctl) disable iff (reset_i)
        (psel_i && !penable_i && pwrite_i && paddr_i == REG_INSTR) |=> !pready_i)
        else begin $error("instruction write finished in its first access cycle"); fail_cnt++; end

    a_done_next: assert property (@(posedge ctl) disable iff (reset_i)
        (cmd_i.valid && rsp_i.last && !(cmd_i.code inside {idiv, irem})) |=> pready_i)
        else begin $error("instruction did not finish one cycle after its last phase"); fail_cnt++; end

endmodule

bind au_top au_props au_props_i (
    .ctl       (ctl),
    .reset_i   (reset_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o),
    .cmd_i     (cmd),
    .rsp_i     (rsp)
);

`default_nettype wire

// ==== dv/au_tb.sv ====
//////////////////////////////////////////////////
// testbench for au_top, apb master tasks and a
// queue reference stack with java semantics
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module au_tb;
    import ej32_pkg::*;

    logic        ctl = 1'b0;
    logic        reset_i;
    logic        psel_i, penable_i, pwrite_i;
    logic [3:0]  paddr_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic        pready_o, pslverr_o;

    int      stk[$];                    // reference stack, back is tos
    opcode_t arith_ops [10] = '{iadd, isub, imul, ineg, iand, ior, ixor, ishl, ishr, iushr};

    au_top au_top_i (.*);

    always #20 ctl = ~ctl;              // 40 ns period

    task automatic stop_on_error();
        $display("tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    // a bound protocol property failure ends the run right away
    always @(au_top_i.au_props_i.fail_cnt) begin
        if (au_top_i.au_props_i.fail_cnt != 0) begin
            $display("apb protocol property failed in the DUT");
            stop_on_error();
        end
    end

    // one apb transfer, inputs change on the falling edge only
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waited;
        @(negedge ctl);
        psel_i    = 1'b1;                // setup
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge ctl);
        penable_i = 1'b1;
        waited    = 0;
        while (!pready_o) begin          // wait states, divider is the longest
            @(negedge ctl);
            waited++;
            if (waited > 4 * DIV_CYCLES) begin
                $display("timeout, no pready on access to address 0x%h", addr);
                stop_on_error();
            end
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(negedge ctl);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic read_check(input logic [3:0] addr, input string name,
                              input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rd, err);
        check(name, rd, exp);
        check("pslverr", {31'h0, err}, 32'h0);
    endtask

    task automatic check_state();
        read_check(REG_TOS, "prdata (tos)", stk.size() > 0 ? stk[$] : 0);
        read_check(REG_NOS, "prdata (nos)", stk.size() > 1 ? stk[$-1] : 0);
        read_check(REG_STATUS, "prdata (status)", stk.size());
    endtask

    // reference model, sets bad when the bytecode must be refused
    task automatic model_step(input opcode_t op, input logic [7:0] b0, input logic [7:0] b1,
                              output bit bad);
        int a;
        int b;
        int need;
        bit grow;
        need = 0;
        grow = 1'b0;
        bad  = 1'b0;
        case (op)
            pop, dup, ineg: need = 1;
            swap, iadd, isub, imul, iand, ior, ixor,
            ishl, ishr, iushr, idiv, irem: need = 2;
            default: grow = 1'b1;        // constants and immediates
        endcase
        if (op == dup) grow = 1'b1;
        if (stk.size() < need) bad = 1'b1;
        else if (grow && stk.size() == SS_DEPTH) bad = 1'b1;
        else if ((op == idiv || op == irem) && stk[$] == 0) bad = 1'b1;
        if (bad) return;                 // state stays as it was
        if (need >= 1) b = stk.pop_back();
        if (need == 2) a = stk.pop_back();
        case (op)
            aconst_null: stk.push_back(0);
            bipush:      stk.push_back({{24{b0[7]}}, b0});
            sipush:      stk.push_back({{16{b0[7]}}, b0, b1});
            pop:         ;
            dup:         begin stk.push_back(b); stk.push_back(b); end
            swap:        begin stk.push_back(b); stk.push_back(a); end
            iadd:        stk.push_back(a + b);
            isub:        stk.push_back(a - b);
            imul:        stk.push_back(a * b);      // low word
            ineg:        stk.push_back(-b);
            iand:        stk.push_back(a & b);
            ior:         stk.push_back(a | b);
            ixor:        stk.push_back(a ^ b);
            ishl:        stk.push_back(a << b[4:0]);
            ishr:        stk.push_back(a >>> b[4:0]);
            iushr:       stk.push_back(int'($unsigned(a) >> b[4:0]));
            idiv:        stk.push_back((a == int'(32'h8000_0000) && b == -1) ? a : a / b);
            irem:        stk.push_back((b == -1) ? 0 : a % b);
            default:     stk.push_back(int'(op) - int'(iconst_0));   // iconst_m1..5
        endcase
    endtask

    task automatic exec(input opcode_t op, input logic [7:0] b0, input logic [7:0] b1);
        bit          bad;
        logic [31:0] rd;
        logic        err;
        model_step(op, b0, b1, bad);
        apb_xfer(1'b1, REG_INSTR, {8'h00, b1, b0, op}, rd, err);
        check("pslverr", {31'h0, err}, {31'h0, bad});
        check_state();
    endtask

    // full 32 bit word built from two 16 bit halves
    task automatic push_word(input logic [31:0] w);
        exec(sipush, w[31:24], w[23:16]);
        exec(bipush, 8'd16, 8'h00);
        exec(ishl, 8'h00, 8'h00);
        exec(sipush, w[15:8], w[7:0]);
        exec(bipush, 8'd16, 8'h00);
        exec(ishl, 8'h00, 8'h00);
        exec(bipush, 8'd16, 8'h00);
        exec(iushr, 8'h00, 8'h00);         // drop sign extension
        exec(ior, 8'h00, 8'h00);
    endtask

    task automatic clear_stack();
        while (stk.size() > 0) exec(pop, 8'h00, 8'h00);
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [31:0] d;
        void'($urandom(47));
        reset_i   = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = 4'h0;
        pwdata_i  = 32'h0;
        repeat (8) @(posedge ctl);
        @(negedge ctl);
        reset_i = 1'b0;

        // reset state, constants, immediates
        check_state();
        for (int c = iconst_m1; c <= iconst_5; c++) exec(opcode_t'(c), 8'h00, 8'h00);
        exec(aconst_null, 8'h00, 8'h00);
        exec(bipush, 8'h85, 8'h00);        // negative byte
        exec(bipush, 8'h7f, 8'h00);
        exec(sipush, 8'h80, 8'h01);
        exec(sipush, 8'h12, 8'h34);

        // alu and shifter on random words
        foreach (arith_ops[i]) begin
            repeat (4) begin
                clear_stack();
                push_word($urandom());
                push_word($urandom());
                exec(arith_ops[i], 8'h00, 8'h00);
            end
        end

        // stack reordering
        clear_stack();
        repeat (3) push_word($urandom());
        exec(dup, 8'h00, 8'h00);
        exec(swap, 8'h00, 8'h00);
        exec(pop, 8'h00, 8'h00);
        exec(swap, 8'h00, 8'h00);
        exec(pop, 8'h00, 8'h00);
        exec(dup, 8'h00, 8'h00);

        // division, random signs and sizes, then min / -1
        repeat (6) begin
            for (int k = 0; k < 2; k++) begin
                d = $urandom() >> ($urandom() % 31);
                if ($urandom() % 2) d = -d;
                clear_stack();
                push_word($urandom());
                push_word(d);
                exec(opcode_t'(k ? irem : idiv), 8'h00, 8'h00);
            end
        end
        for (int k = 0; k < 2; k++) begin
            clear_stack();
            push_word(32'h8000_0000);
            push_word(32'hffff_ffff);
            exec(opcode_t'(k ? irem : idiv), 8'h00, 8'h00);
        end

        // error responses leave state alone
        clear_stack();
        exec(pop, 8'h00, 8'h00);           // underflow
        exec(bipush, 8'h05, 8'h00);
        exec(iadd, 8'h00, 8'h00);
        clear_stack();
        repeat (SS_DEPTH) exec(bipush, 8'($urandom()), 8'h00);
        exec(iconst_1, 8'h00, 8'h00);      // overflow
        clear_stack();
        push_word(32'h0000_0007);
        exec(iconst_0, 8'h00, 8'h00);
        exec(idiv, 8'h00, 8'h00);          // zero divisor
        apb_xfer(1'b1, REG_TOS, $urandom(), rd, err);
        check("pslverr", {31'h0, err}, 32'h1);
        check_state();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/ej32_pkg.sv
source/au_divider.sv
source/au_core.sv
source/au_apb_port.sv
source/au_top.sv
dv/au_props.sv
dv/au_tb.sv

// ==== source/au_apb_port.sv ====
//////////////////////////////////////////////////
// apb3 slave front end, turns an instruction write
// into command phases and holds pready until done
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module au_apb_port (
    input  wire                    ctl,
    input  wire                    reset_i,
    input  wire logic              psel_i,
    input  wire logic              penable_i,
    input  wire logic              pwrite_i,
    input  wire logic [3:0]        paddr_i,
    input  wire logic [31:0]       pwdata_i,
    input  wire ej32_pkg::au_rsp_t rsp_i,
    output ej32_pkg::au_cmd_t      cmd_o,
    output logic [31:0]            prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o
);
    import ej32_pkg::*;

    typedef enum logic [1:0] {st_idle, st_issue, st_respond} state_t;

    state_t      state;
    logic [1:0]  phase;                 // current instruction phase
    logic [23:0] word_q;                // latched opcode + immediates
    logic        err_q;                 // error response pending
    logic        setup;
    logic        instr_wr;
    logic        rd_ok;

    assign setup    = psel_i && !penable_i;             // apb setup cycle
    assign instr_wr = pwrite_i && (paddr_i == REG_INSTR);
    assign rd_ok    = !pwrite_i && (paddr_i == REG_TOS || paddr_i == REG_NOS ||
                                    paddr_i == REG_STATUS);

    always_ff @(posedge ctl) begin
        if (reset_i) begin
            state <= st_idle;
            phase <= '0;
            err_q <= 1'b0;
        end else begin
            case (state)
                st_idle: if (setup) begin
                    phase <= '0;
                    err_q <= !(instr_wr || rd_ok);         // bad access, answer at once
                    state <= instr_wr ? st_issue : st_respond;
                end
                st_issue: begin
                    if (rsp_i.err || rsp_i.done) begin     // last phase seen
                        err_q <= rsp_i.err;
                        state <= st_respond;
                    end else if (!rsp_i.busy) begin
                        phase <= phase + 2'd1;             // next phase
                    end
                end
                st_respond: begin
                    err_q <= 1'b0;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // instruction payload, captured in the setup cycle
    always_ff @(posedge ctl) begin
        if (state == st_idle && setup && instr_wr) begin
            word_q <= pwdata_i[23:0];
        end
    end

    assign cmd_o.valid = (state == st_issue);
    assign cmd_o.code  = opcode_t'(word_q[7:0]);
    assign cmd_o.phase = phase;
    assign cmd_o.imm0  = word_q[15:8];
    assign cmd_o.imm1  = word_q[23:16];

    assign pready_o  = (state == st_respond);
    assign pslverr_o = err_q;               // only set while responding

    // read mux, core state is stable while no instruction runs
    always_comb begin
        case (paddr_i)
            REG_TOS:    prdata_o = rsp_i.tos;
            REG_NOS:    prdata_o = rsp_i.nos;
            REG_STATUS: prdata_o = {{(32-SP_W){1'b0}}, rsp_i.depth};
            default:    prdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/au_core.sv ====
//////////////////////////////////////////////////
// stack machine core, tos register plus stack array
// and depth counter, one committed phase per clock
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module au_core (
    input  wire                     ctl,
    input  wire                     reset_i,
    input  wire ej32_pkg::au_cmd_t  cmd_i,
    input  wire ej32_pkg::div_rsp_t div_rsp_i,
    output ej32_pkg::au_rsp_t       rsp_o,
    output ej32_pkg::div_req_t      div_req_o
);
    import ej32_pkg::*;

    logic [DSZ-1:0]  ss [SS_DEPTH];     // entries below tos, slot 0 spare
    logic [DSZ-1:0]  t;                 // tos
    logic [SP_W-1:0] depth;             // entries incl. tos
    logic [SP_W-2:0] push_idx, nos_idx;
    logic [DSZ-1:0]  s;                 // nos, zero when absent
    logic [DSZ-1:0]  t_n;               // next tos
    logic            t_x;               // tos update flag
    stack_op_t       ss_op;
    logic            last_d;
    logic [SP_W-1:0] need;              // depth required by the opcode
    logic            grow;              // opcode adds an entry
    logic            bad_op;
    logic            div_op;
    logic            err;
    logic            hold;              // waiting on divider
    logic            commit;
    logic [7:0]      k;
    logic [DSZ-1:0]  const_v, imm_b, alu_v, mul_lo, sh_l, sh_r;
    logic [4:0]      shamt;

    assign push_idx = depth[SP_W-2:0];
    assign nos_idx  = depth[SP_W-2:0] - 1'b1;  // wraps to 31 at full depth
    assign s        = (depth >= SP_W'(2)) ? ss[nos_idx] : '0;

    // constants and immediates
    assign k       = cmd_i.code - 8'd3;                 // iconst_0 -> 0
    assign const_v = (cmd_i.code == aconst_null) ? '0 : {{(DSZ-8){k[7]}}, k};
    assign imm_b   = {{(DSZ-8){cmd_i.imm0[7]}}, cmd_i.imm0};

    // multiplier and shifter
    assign mul_lo = s * t;                              // low word only
    assign shamt  = t[4:0];
    assign sh_l   = s << shamt;
    assign sh_r   = $signed(s) >>> shamt;               // sign fill for ishr

    always_comb begin
        case (cmd_i.code)
            iadd:        alu_v = s + t;
            isub:        alu_v = s - t;
            imul:        alu_v = mul_lo;
            iand:        alu_v = s & t;
            ior:         alu_v = s | t;
            ixor:        alu_v = s ^ t;
            ishl:        alu_v = sh_l;
            ishr:        alu_v = sh_r;
            iushr:       alu_v = s >> shamt;            // zero fill
            idiv:        alu_v = div_rsp_i.quotient;
            irem:        alu_v = div_rsp_i.remainder;
            default:     alu_v = '0;
        endcase
    end

    // bytecode dispatcher
    always_comb begin
        t_n    = t;
        t_x    = 1'b0;
        ss_op  = s_nop;
        last_d = 1'b1;
        need   = '0;
        grow   = 1'b0;
        bad_op = 1'b0;
        case (cmd_i.code)
            aconst_null, iconst_m1, iconst_0, iconst_1,
            iconst_2, iconst_3, iconst_4, iconst_5: begin
                t_n   = const_v;
                t_x   = 1'b1;
                ss_op = s_push;
                grow  = 1'b1;
            end
            bipush: begin
                t_n   = imm_b;
                t_x   = 1'b1;
                ss_op = s_push;
                grow  = 1'b1;
            end
            sipush: begin
                t_x = 1'b1;
                if (cmd_i.phase == 2'd0) begin
                    t_n    = imm_b;                     // high byte first
                    ss_op  = s_push;
                    grow   = 1'b1;
                    last_d = 1'b0;
                end else begin
                    t_n = {t[DSZ-9:0], cmd_i.imm1};     // merge low byte
                end
            end
            pop: begin
                t_n   = s;
                t_x   = 1'b1;
                ss_op = s_pop;
                need  = SP_W'(1);
            end
            dup: begin
                ss_op = s_push;                         // old tos becomes nos
                need  = SP_W'(1);
                grow  = 1'b1;
            end
            swap: begin
                t_n   = s;
                t_x   = 1'b1;
                ss_op = s_move;
                need  = SP_W'(2);
            end
            ineg: begin
                t_n  = '0 - t;
                t_x  = 1'b1;
                need = SP_W'(1);
            end
            iadd, isub, imul, iand, ior, ixor, ishl, ishr, iushr: begin
                t_n   = alu_v;
                t_x   = 1'b1;
                ss_op = s_pop;
                need  = SP_W'(2);
            end
            idiv, irem: begin
                need = SP_W'(2);
                if (cmd_i.phase == 2'd0) begin
                    last_d = 1'b0;                      // start only
                end else begin
                    t_n   = alu_v;
                    t_x   = 1'b1;
                    ss_op = s_pop;
                end
            end
            default: bad_op = 1'b1;                     // unsupported bytecode
        endcase
    end

    assign div_op = (cmd_i.code == idiv) || (cmd_i.code == irem);

    // checks only in phase 0, later phases were already cleared
    assign err = cmd_i.valid && (cmd_i.phase == 2'd0) &&
                 (bad_op || (depth < need) ||
                  (grow && depth == SP_W'(SS_DEPTH)) ||
                  (div_op && t == '0));
    assign hold   = cmd_i.valid && div_op && (cmd_i.phase == 2'd1) && div_rsp_i.busy;
    assign commit = cmd_i.valid && !err && !hold;

    always_ff @(posedge ctl) begin
        if (reset_i) begin
            t     <= '0;
            depth <= '0;
        end else if (commit) begin
            if (t_x) t <= t_n;
            case (ss_op)
                s_push:  depth <= depth + 1'b1;
                s_pop:   depth <= depth - 1'b1;
                default: depth <= depth;
            endcase
        end
    end

    // stack array
    always_ff @(posedge ctl) begin
        if (commit) begin
            case (ss_op)
                s_push:  ss[push_idx] <= t;
                s_move:  ss[nos_idx]  <= t;             // swap
                default: ;
            endcase
        end
    end

    assign div_req_o.start    = cmd_i.valid && div_op && (cmd_i.phase == 2'd0) && !err;
    assign div_req_o.dividend = s;
    assign div_req_o.divisor  = t;

    assign rsp_o.tos   = t;
    assign rsp_o.nos   = s;
    assign rsp_o.depth = depth;
    assign rsp_o.busy  = hold;
    assign rsp_o.last  = last_d || err;
    assign rsp_o.err   = err;
    assign rsp_o.done  = commit && last_d;

endmodule

`default_nettype wire

// ==== source/au_divider.sv ====
//////////////////////////////////////////////////
// signed restoring divider for idiv and irem,
// busy for DIV_CYCLES clocks after start
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module au_divider (
    input  wire                     ctl,
    input  wire                     reset_i,
    input  wire ej32_pkg::div_req_t req_i,
    output ej32_pkg::div_rsp_t      rsp_o
);
    import ej32_pkg::*;

    logic [DIV_CNT_W-1:0] cnt;          // iterations left
    logic                 busy;
    logic [DSZ-1:0]       rem_q;        // partial remainder
    logic [DSZ-1:0]       quo_q;        // dividend shifts out, quotient in
    logic [DSZ-1:0]       dvs_q;        // divisor magnitude
    logic                 neg_q;        // signs differ
    logic                 neg_r;        // dividend negative
    logic [DSZ-1:0]       a_mag, b_mag;
    logic [DSZ:0]         rem_sh, trial;

    assign a_mag  = req_i.dividend[DSZ-1] ? '0 - req_i.dividend : req_i.dividend;
    assign b_mag  = req_i.divisor[DSZ-1]  ? '0 - req_i.divisor  : req_i.divisor;
    assign rem_sh = {rem_q, quo_q[DSZ-1]};              // shift in next bit
    assign trial  = rem_sh - {1'b0, dvs_q};

    always_ff @(posedge ctl) begin
        if (reset_i) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (req_i.start) begin
            busy <= 1'b1;
            cnt  <= DIV_CNT_W'(DIV_CYCLES);
        end else if (busy) begin
            cnt <= cnt - 1'b1;
            if (cnt == DIV_CNT_W'(1)) busy <= 1'b0;      // last iteration
        end
    end

    always_ff @(posedge ctl) begin
        if (req_i.start) begin
            rem_q <= '0;
            quo_q <= a_mag;                             // 2^31 fits unsigned
            dvs_q <= b_mag;
            neg_q <= req_i.dividend[DSZ-1] ^ req_i.divisor[DSZ-1];
            neg_r <= req_i.dividend[DSZ-1];
        end else if (busy) begin
            if (!trial[DSZ]) begin                      // fits, keep difference
                rem_q <= trial[DSZ-1:0];
                quo_q <= {quo_q[DSZ-2:0], 1'b1};
            end else begin                              // restore
                rem_q <= rem_sh[DSZ-1:0];
                quo_q <= {quo_q[DSZ-2:0], 1'b0};
            end
        end
    end

    // sign fixup, min / -1 wraps back to min
    assign rsp_o.busy      = busy;
    assign rsp_o.quotient  = neg_q ? '0 - quo_q : quo_q;
    assign rsp_o.remainder = neg_r ? '0 - rem_q : rem_q;

endmodule

`default_nettype wire

// ==== source/au_top.sv ====
//////////////////////////////////////////////////
// arithmetic unit top, apb port + core + divider
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module au_top (
    input  wire              ctl,
    input  wire              reset_i,
    input  wire logic        psel_i,
    input  wire logic        penable_i,
    input  wire logic        pwrite_i,
    input  wire logic [3:0]  paddr_i,
    input  wire logic [31:0] pwdata_i,
    output logic [31:0]      prdata_o,
    output logic             pready_o,
    output logic             pslverr_o
);
    import ej32_pkg::*;

    au_cmd_t  cmd;                      // port -> core
    au_rsp_t  rsp;                      // core -> port
    div_req_t div_req;
    div_rsp_t div_rsp;

    au_apb_port au_apb_port_i (
        .ctl       (ctl),
        .reset_i   (reset_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .rsp_i     (rsp),
        .cmd_o     (cmd),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o)
    );

    au_core au_core_i (
        .ctl       (ctl),
        .reset_i   (reset_i),
        .cmd_i     (cmd),
        .div_rsp_i (div_rsp),
        .rsp_o     (rsp),
        .div_req_o (div_req)
    );

    au_divider au_divider_i (
        .ctl     (ctl),
        .reset_i (reset_i),
        .req_i   (div_req),
        .rsp_o   (div_rsp)
    );

endmodule

`default_nettype wire

// ==== source/ej32_pkg.sv ====
//////////////////////////////////////////////////
// shared types and constants for the eJ32 style
// arithmetic unit, imported by every RTL module
//////////////////////////////////////////////////
`default_nettype none

package ej32_pkg;

    localparam int DSZ        = 32;     // data width
    localparam int SS_DEPTH   = 32;     // stack entries incl. tos
    localparam int SP_W       = 6;      // depth counter, counts 0..SS_DEPTH
    localparam int DIV_CYCLES = 32;     // one iteration per quotient bit
    localparam int DIV_CNT_W  = $clog2(DIV_CYCLES + 1);

    // apb register map
    localparam logic [3:0] REG_INSTR  = 4'h0;  // wo: opcode, imm0, imm1
    localparam logic [3:0] REG_TOS    = 4'h4;  // ro
    localparam logic [3:0] REG_NOS    = 4'h8;  // ro
    localparam logic [3:0] REG_STATUS = 4'hC;  // ro: depth in [5:0]

    // java bytecode values, only the supported subset
    typedef enum logic [7:0] {
        aconst_null = 8'h01,
        iconst_m1   = 8'h02,
        iconst_0    = 8'h03,
        iconst_1    = 8'h04,
        iconst_2    = 8'h05,
        iconst_3    = 8'h06,
        iconst_4    = 8'h07,
        iconst_5    = 8'h08,
        bipush      = 8'h10,
        sipush      = 8'h11,
        pop         = 8'h57,
        dup         = 8'h59,
        swap        = 8'h5f,
        iadd        = 8'h60,
        isub        = 8'h64,
        imul        = 8'h68,
        idiv        = 8'h6c,
        irem        = 8'h70,
        ineg        = 8'h74,
        ishl        = 8'h78,
        ishr        = 8'h7a,
        iushr       = 8'h7c,
        iand        = 8'h7e,
        ior         = 8'h80,
        ixor        = 8'h82
    } opcode_t;

    typedef enum logic [1:0] {s_nop, s_push, s_pop, s_move} stack_op_t;

    typedef struct packed {
        logic       valid;
        opcode_t    code;
        logic [1:0] phase;
        logic [7:0] imm0;
        logic [7:0] imm1;
    } au_cmd_t;                         // port -> core, 27 bits

    typedef struct packed {
        logic [DSZ-1:0]  tos;
        logic [DSZ-1:0]  nos;
        logic [SP_W-1:0] depth;
        logic            busy;          // phase held, divider running
        logic            last;          // final phase of the opcode
        logic            err;
        logic            done;          // final phase commits this cycle
    } au_rsp_t;                         // core -> port, 74 bits

    typedef struct packed {
        logic           start;
        logic [DSZ-1:0] dividend;
        logic [DSZ-1:0] divisor;
    } div_req_t;

    typedef struct packed {
        logic           busy;
        logic [DSZ-1:0] quotient;
        logic [DSZ-1:0] remainder;
    } div_rsp_t;

endpackage

`default_nettype wire
